// ==== src/div_settings.svh ====
// Width and timing settings shared by the division unit and its testbench
// DIV_LATENCY counts enabled clock cycles only, from the accepting edge
// to the edge that raises data_valid_o

`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// Operand and result width in bits
`define DIV_DATA_WIDTH 32

// ------------------------------
// Fixed latency of one operation
// ------------------------------
// One input register, one load cycle, one cycle per quotient bit,
// one restore cycle, one finish cycle and one output register
`define DIV_LATENCY (`DIV_DATA_WIDTH + 4)

`endif

// ==== src/div_pkg.sv ====
// Types shared by the blocks of the division unit
// The operation encoding follows the order DIV, DIVU, REM, REMU

package div_pkg;

    // The four M-extension divide operations
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_operation_t;

    // Which result of the division leaves the unit
    typedef enum logic {
        QUOTIENT  = 1'b0,
        REMAINDER = 1'b1
    } div_select_t;

    // Control states of the sequential divider core
    typedef enum logic [1:0] {
        DIV_IDLE    = 2'b00,
        DIV_ITERATE = 2'b01,
        DIV_RESTORE = 2'b10,
        DIV_FINISH  = 2'b11
    } div_state_t;

endpackage : div_pkg

// ==== src/div_operand_conditioner.sv ====
// Input side of the division unit
// Operands are registered only on an accepted operation; the outputs then
// hold until the next acceptance. Signed operands become magnitudes here

`timescale 1ns/1ps

`include "div_settings.svh"

module div_operand_conditioner (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         clk_en_i,
    input  logic                         data_valid_i,
    input  logic                         accept_i,
    input  logic [`DIV_DATA_WIDTH - 1:0] dividend_i,
    input  logic [`DIV_DATA_WIDTH - 1:0] divisor_i,
    input  div_pkg::div_operation_t      operation_i,
    output logic [`DIV_DATA_WIDTH - 1:0] dividend_mag_o,
    output logic [`DIV_DATA_WIDTH - 1:0] divisor_mag_o,
    output logic                         start_o,
    output logic                         negate_quotient_o,
    output logic                         negate_remainder_o,
    output div_pkg::div_select_t         result_select_o
);

    import div_pkg::*;

    logic                         is_signed;
    logic                         dividend_neg;
    logic                         divisor_neg;
    logic                         load;
    logic [`DIV_DATA_WIDTH - 1:0] dividend_mag;
    logic [`DIV_DATA_WIDTH - 1:0] divisor_mag;
    div_select_t                  result_select;

    // ------------------------------
    // Sign handling
    // ------------------------------

    // Only DIV and REM look at the operand signs
    assign is_signed = (operation_i == DIV) || (operation_i == REM);

    assign dividend_neg = is_signed & dividend_i[`DIV_DATA_WIDTH - 1];
    assign divisor_neg  = is_signed & divisor_i[`DIV_DATA_WIDTH - 1];

    // Two's-complement magnitude; the most negative value maps onto itself,
    // which reads correctly as an unsigned magnitude
    assign dividend_mag = dividend_neg ? (~dividend_i + 1'b1) : dividend_i;
    assign divisor_mag  = divisor_neg ? (~divisor_i + 1'b1) : divisor_i;

    // REM and REMU deliver the remainder, DIV and DIVU the quotient
    assign result_select = ((operation_i == REM) || (operation_i == REMU)) ? REMAINDER : QUOTIENT;

    // Load strobe for the operand registers
    assign load = accept_i & data_valid_i;

    // ------------------------------
    // Registers
    // ------------------------------

    // Magnitudes for the core, captured on acceptance
    always_ff @(posedge clk_i) begin
        if (load) begin
            dividend_mag_o <= dividend_mag;
            divisor_mag_o  <= divisor_mag;
        end
    end

    // Start pulse trails the acceptance by one enabled cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            start_o            <= 1'b0;
            negate_quotient_o  <= 1'b0;
            negate_remainder_o <= 1'b0;
            result_select_o    <= QUOTIENT;
        end else if (clk_en_i) begin
            start_o <= load;
            if (load) begin
                // Quotient is negative when exactly one operand is
                negate_quotient_o  <= dividend_neg ^ divisor_neg;
                // Remainder takes the sign of the dividend
                negate_remainder_o <= dividend_neg;
                result_select_o    <= result_select;
            end
        end
    end

endmodule : div_operand_conditioner

// ==== src/non_restoring_divider.sv ====
// Sequential non-restoring divider on unsigned magnitudes
// One quotient bit per enabled cycle. A start while busy is ignored
// With a zero divisor the quotient is all ones and the remainder is the dividend

`timescale 1ns/1ps

module non_restoring_divider #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    clk_en_i,
    input  logic [DATA_WIDTH - 1:0] dividend_i,
    input  logic [DATA_WIDTH - 1:0] divisor_i,
    input  logic                    data_valid_i,
    output logic [DATA_WIDTH - 1:0] quotient_o,
    output logic [DATA_WIDTH - 1:0] remainder_o,
    output logic                    divide_by_zero_o,
    output logic                    data_valid_o,
    output logic                    idle_o
);

    import div_pkg::*;

    localparam int CNT_WIDTH = $clog2(DATA_WIDTH);
    localparam logic [CNT_WIDTH - 1:0] LAST_ITERATION = CNT_WIDTH'(DATA_WIDTH - 1);

    div_state_t              state_q;
    logic [CNT_WIDTH - 1:0]  iteration_q;

    // Partial remainder carries one extra bit for its sign
    logic [DATA_WIDTH:0]     partial_q;
    // Dividend bits shift out of the top while quotient bits enter at the bottom
    logic [DATA_WIDTH - 1:0] quotient_q;
    logic [DATA_WIDTH - 1:0] divisor_q;

    logic [DATA_WIDTH:0]     divisor_ext;
    logic [DATA_WIDTH:0]     shifted;
    logic [DATA_WIDTH:0]     next_partial;
    logic                    load;

    // ------------------------------
    // Iteration datapath
    // ------------------------------

    assign divisor_ext = {1'b0, divisor_q};

    // Shift the next dividend bit into the partial remainder
    assign shifted = {partial_q[DATA_WIDTH - 1:0], quotient_q[DATA_WIDTH - 1]};

    // A negative partial remainder adds the divisor back, a positive one subtracts it
    assign next_partial = partial_q[DATA_WIDTH] ? (shifted + divisor_ext)
                                                : (shifted - divisor_ext);

    assign load = data_valid_i && (state_q == DIV_IDLE);

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            unique case (state_q)
                DIV_IDLE: begin
                    if (load) begin
                        partial_q  <= '0;
                        quotient_q <= dividend_i;
                        divisor_q  <= divisor_i;
                    end
                end

                DIV_ITERATE: begin
                    partial_q <= next_partial;
                    // Quotient bit is set when the new partial remainder is not negative
                    quotient_q <= {quotient_q[DATA_WIDTH - 2:0], ~next_partial[DATA_WIDTH]};
                end

                DIV_RESTORE: begin
                    // Bring a negative final remainder back into range
                    if (partial_q[DATA_WIDTH]) begin
                        partial_q <= partial_q + divisor_ext;
                    end
                end

                default: begin
                    partial_q <= partial_q;
                end
            endcase
        end
    end

    // ------------------------------
    // Control FSM
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q          <= DIV_IDLE;
            iteration_q      <= '0;
            divide_by_zero_o <= 1'b0;
            data_valid_o     <= 1'b0;
        end else if (clk_en_i) begin
            // Valid is a single-cycle pulse unless the finish state sets it
            data_valid_o <= 1'b0;

            unique case (state_q)
                DIV_IDLE: begin
                    if (load) begin
                        state_q          <= DIV_ITERATE;
                        iteration_q      <= '0;
                        divide_by_zero_o <= (divisor_i == '0);
                    end
                end

                DIV_ITERATE: begin
                    iteration_q <= iteration_q + 1'b1;
                    if (iteration_q == LAST_ITERATION) begin
                        state_q <= DIV_RESTORE;
                    end
                end

                DIV_RESTORE: begin
                    state_q <= DIV_FINISH;
                end

                DIV_FINISH: begin
                    data_valid_o <= 1'b1;
                    state_q      <= DIV_IDLE;
                end

                default: begin
                    state_q <= DIV_IDLE;
                end
            endcase
        end
    end

    // Results hold in the working registers until the next load
    assign quotient_o  = quotient_q;
    assign remainder_o = partial_q[DATA_WIDTH - 1:0];

    assign idle_o = (state_q == DIV_IDLE);

endmodule : non_restoring_divider

// ==== src/div_result_corrector.sv ====
// Output side of the division unit
// Results arrive as unsigned magnitudes from the core and leave signed
// as the operation requires. result_o holds until the next core result

`timescale 1ns/1ps

`include "div_settings.svh"

module div_result_corrector (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         clk_en_i,
    input  logic [`DIV_DATA_WIDTH - 1:0] quotient_i,
    input  logic [`DIV_DATA_WIDTH - 1:0] remainder_i,
    input  logic                         zero_divisor_i,
    input  logic                         core_valid_i,
    input  logic                         negate_quotient_i,
    input  logic                         negate_remainder_i,
    input  div_pkg::div_select_t         result_select_i,
    output logic [`DIV_DATA_WIDTH - 1:0] result_o,
    output logic                         data_valid_o,
    output logic                         divide_by_zero_o
);

    import div_pkg::*;

    logic [`DIV_DATA_WIDTH - 1:0] signed_quotient;
    logic [`DIV_DATA_WIDTH - 1:0] signed_remainder;
    logic [`DIV_DATA_WIDTH - 1:0] selected;
    logic                         fix_quotient;

    // ------------------------------
    // Sign restore
    // ------------------------------

    // A zero divisor keeps the all-ones quotient whatever the operand signs
    assign fix_quotient = negate_quotient_i & ~zero_divisor_i;

    assign signed_quotient = fix_quotient ? (~quotient_i + 1'b1) : quotient_i;

    // For a zero divisor the core hands back the dividend magnitude,
    // so restoring the dividend sign yields the original dividend
    assign signed_remainder = negate_remainder_i ? (~remainder_i + 1'b1) : remainder_i;

    assign selected = (result_select_i == REMAINDER) ? signed_remainder : signed_quotient;

    // ------------------------------
    // Output registers
    // ------------------------------

    // Result register only loads on a core result
    always_ff @(posedge clk_i) begin
        if (clk_en_i && core_valid_i) begin
            result_o <= selected;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_valid_o     <= 1'b0;
            divide_by_zero_o <= 1'b0;
        end else if (clk_en_i) begin
            // One-cycle pulse following the core pulse
            data_valid_o <= core_valid_i;
            // Zero flag stays with the result it belongs to
            if (core_valid_i) begin
                divide_by_zero_o <= zero_divisor_i;
            end
        end
    end

endmodule : div_result_corrector

// ==== src/division_unit.sv ====
// RV32 M-extension division unit for DIV, DIVU, REM and REMU
// One operation at a time, DIV_LATENCY enabled cycles each; data_valid_i is
// ignored while idle_o is low. idle_o is high again in the result cycle

`timescale 1ns/1ps

`include "div_settings.svh"

module division_unit (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         clk_en_i,
    input  logic [`DIV_DATA_WIDTH - 1:0] dividend_i,
    input  logic [`DIV_DATA_WIDTH - 1:0] divisor_i,
    input  logic                         data_valid_i,
    input  div_pkg::div_operation_t      operation_i,
    output logic [`DIV_DATA_WIDTH - 1:0] result_o,
    output logic                         data_valid_o,
    output logic                         divide_by_zero_o,
    output logic                         idle_o
);

    import div_pkg::*;

    logic [`DIV_DATA_WIDTH - 1:0] dividend_mag;
    logic [`DIV_DATA_WIDTH - 1:0] divisor_mag;
    logic [`DIV_DATA_WIDTH - 1:0] quotient;
    logic [`DIV_DATA_WIDTH - 1:0] remainder;
    logic                         start;
    logic                         negate_quotient;
    logic                         negate_remainder;
    div_select_t                  result_select;
    logic                         zero_divisor;
    logic                         core_valid;
    logic                         core_idle;
    logic                         accept;
    logic                         busy_q;

    // ------------------------------
    // Acceptance and busy tracking
    // ------------------------------

    assign accept = data_valid_i & clk_en_i & idle_o;

    // Busy spans acceptance up to the edge that raises data_valid_o
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (clk_en_i) begin
            if (accept) begin
                busy_q <= 1'b1;
            end else if (core_valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign idle_o = ~busy_q & core_idle;

    div_operand_conditioner operand_conditioner_inst (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .clk_en_i           (clk_en_i),
        .data_valid_i       (data_valid_i),
        .accept_i           (accept),
        .dividend_i         (dividend_i),
        .divisor_i          (divisor_i),
        .operation_i        (operation_i),
        .dividend_mag_o     (dividend_mag),
        .divisor_mag_o      (divisor_mag),
        .start_o            (start),
        .negate_quotient_o  (negate_quotient),
        .negate_remainder_o (negate_remainder),
        .result_select_o    (result_select)
    );

    // Core result pulse comes DIV_DATA_WIDTH + 2 cycles after its start edge
    non_restoring_divider #(
        .DATA_WIDTH (`DIV_DATA_WIDTH)
    ) divider_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .clk_en_i         (clk_en_i),
        .dividend_i       (dividend_mag),
        .divisor_i        (divisor_mag),
        .data_valid_i     (start),
        .quotient_o       (quotient),
        .remainder_o      (remainder),
        .divide_by_zero_o (zero_divisor),
        .data_valid_o     (core_valid),
        .idle_o           (core_idle)
    );

    div_result_corrector result_corrector_inst (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .clk_en_i           (clk_en_i),
        .quotient_i         (quotient),
        .remainder_i        (remainder),
        .zero_divisor_i     (zero_divisor),
        .core_valid_i       (core_valid),
        .negate_quotient_i  (negate_quotient),
        .negate_remainder_i (negate_remainder),
        .result_select_i    (result_select),
        .result_o           (result_o),
        .data_valid_o       (data_valid_o),
        .divide_by_zero_o   (divide_by_zero_o)
    );

endmodule : division_unit

// ==== verif/division_unit_assertions.sv ====
// Timing checks on the control outputs of the division unit when bound into it
// Latency is counted in enabled cycles, so clock enable stalls move the result
// later by exactly the number of stalled cycles

`timescale 1ns/1ps

`include "div_settings.svh"

module division_unit_assertions (
    input logic clk_i,
    input logic rst_n_i,
    input logic clk_en_i,
    input logic data_valid_i,
    input logic result_valid_i,
    input logic divide_by_zero_i,
    input logic idle_i
);

    logic accept;
    logic pending_q;
    int   enabled_cycles_q;
    int   failure_count = 0;

    // Same acceptance rule as the unit itself
    assign accept = data_valid_i && clk_en_i && idle_i;

    // Enabled cycles since the last accepted operation
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q        <= 1'b0;
            enabled_cycles_q <= 0;
        end else if (accept) begin
            pending_q        <= 1'b1;
            enabled_cycles_q <= 0;
        end else if (result_valid_i) begin
            pending_q <= 1'b0;
        end else if (clk_en_i && pending_q) begin
            enabled_cycles_q <= enabled_cycles_q + 1;
        end
    end

    // ------------------------------
    // Reset and result timing
    // ------------------------------

    reset_state: assert property (@(posedge clk_i)
        !rst_n_i |=> !result_valid_i && !divide_by_zero_i && idle_i
    ) else begin
        failure_count++;
        $error("outputs are not in their reset state one cycle after reset");
    end

    // Result arrives a fixed number of enabled cycles after acceptance
    result_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(result_valid_i) |-> pending_q && (enabled_cycles_q == `DIV_LATENCY)
    ) else begin
        failure_count++;
        $error("data_valid_o rose after %0d enabled cycles", enabled_cycles_q);
    end

    single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_valid_i && clk_en_i |=> !result_valid_i
    ) else begin
        failure_count++;
        $error("data_valid_o stayed high for more than one enabled cycle");
    end

    // ------------------------------
    // Idle level
    // ------------------------------

    idle_falls: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accept |=> !idle_i
    ) else begin
        failure_count++;
        $error("idle_o did not fall in the cycle after acceptance");
    end

    // Busy covers the whole operation, so requests in between are dropped
    idle_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pending_q && !result_valid_i |-> !idle_i
    ) else begin
        failure_count++;
        $error("idle_o went high before the result was delivered");
    end

    idle_with_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_valid_i |-> idle_i
    ) else begin
        failure_count++;
        $error("idle_o is low while data_valid_o is high");
    end

endmodule : division_unit_assertions

// ==== verif/division_unit_tb.sv ====
// Testbench for the RV32 division unit
// Inputs change on the falling clock edge. Each result is compared with a
// reference model of the RV32 division rules when data_valid_o arrives
// The timing rules live in the bound assertion module

`timescale 1ns/1ps

`include "div_settings.svh"

module division_unit_tb;

    import div_pkg::*;

    localparam int W = `DIV_DATA_WIDTH;
    localparam logic [W - 1:0] MOST_NEGATIVE = {1'b1, {(W - 1){1'b0}}};
    // Seven unsigned and nine signed operand pairs, then sixteen zero-divisor cases
    localparam int DIRECTED_OPS = 2 * 7 + 2 * 9 + 16;
    localparam int RANDOM_OPS = 48;
    localparam int TIMEOUT_CYCLES = (DIRECTED_OPS + RANDOM_OPS) * (`DIV_LATENCY + 2) + 50;

    logic           clk_i;
    logic           rst_n_i;
    logic           clk_en_i;
    logic [W - 1:0] dividend_i;
    logic [W - 1:0] divisor_i;
    logic           data_valid_i;
    div_operation_t operation_i;
    logic [W - 1:0] result_o;
    logic           data_valid_o;
    logic           divide_by_zero_o;
    logic           idle_o;

    integer         seed;
    int             value_errors;
    int             cycle_count;
    logic [W - 1:0] expected_q[$];
    logic           zero_q[$];
    logic [1:0]     rand_op;
    logic [W - 1:0] rand_dividend;
    logic [W - 1:0] rand_divisor;

    division_unit division_unit_inst (.*);

    bind division_unit division_unit_assertions assertions_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .clk_en_i         (clk_en_i),
        .data_valid_i     (data_valid_i),
        .result_valid_i   (data_valid_o),
        .divide_by_zero_i (divide_by_zero_o),
        .idle_i           (idle_o)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
    end

    // Under the RV32 rules a zero divisor gives all ones or the dividend, and
    // signed overflow gives the most negative value and no remainder
    function automatic logic [W - 1:0] reference_result(input div_operation_t op,
                                                       input logic [W - 1:0] a,
                                                       input logic [W - 1:0] b);
        logic signed [W - 1:0] sa;
        logic signed [W - 1:0] sb;
        logic [W - 1:0]        value;
        sa = a;
        sb = b;
        if (b == '0) begin
            value = (op == DIV || op == DIVU) ? '1 : a;
        end else if ((op == DIV || op == REM) && a == MOST_NEGATIVE && b == '1) begin
            value = (op == DIV) ? MOST_NEGATIVE : '0;
        end else begin
            // Signed division truncates toward zero, remainder keeps the dividend sign
            case (op)
                DIV:     value = sa / sb;
                DIVU:    value = a / b;
                REM:     value = sa % sb;
                default: value = a % b;
            endcase
        end
        return value;
    endfunction

    task automatic run_operation(input div_operation_t op, input logic [W - 1:0] a,
                                 input logic [W - 1:0] b, input int busy_pulses,
                                 input int stall_cycles);
        logic [W - 1:0] expected;
        logic           expected_zero;
        expected_q.push_back(reference_result(op, a, b));
        zero_q.push_back(b == '0);
        while (!idle_o) @(negedge clk_i);
        operation_i  = op;
        dividend_i   = a;
        divisor_i    = b;
        data_valid_i = 1'b1;
        @(negedge clk_i);
        data_valid_i = 1'b0;
        // Requests while busy must leave the result and its timing alone
        repeat (busy_pulses) begin
            @(negedge clk_i);
            dividend_i   = ~a;
            divisor_i    = ~b;
            data_valid_i = 1'b1;
            @(negedge clk_i);
            data_valid_i = 1'b0;
        end
        if (stall_cycles > 0) begin
            repeat (3) @(negedge clk_i);
            clk_en_i = 1'b0;
            repeat (stall_cycles) @(negedge clk_i);
            clk_en_i = 1'b1;
        end
        while (!data_valid_o) @(negedge clk_i);
        expected      = expected_q.pop_front();
        expected_zero = zero_q.pop_front();
        assert (result_o === expected && divide_by_zero_o === expected_zero) else begin
            $display("error at %0t: %s %h / %h expected %h zero %b, got %h zero %b",
                     $time, op.name(), a, b, expected, expected_zero, result_o,
                     divide_by_zero_o);
            value_errors++;
        end
    endtask

    // Quotient then remainder on the same operands
    task automatic run_pair(input logic signed_op, input logic [W - 1:0] a,
                            input logic [W - 1:0] b, input int busy_pulses,
                            input int stall_cycles);
        if (signed_op) begin
            run_operation(DIV, a, b, busy_pulses, stall_cycles);
            run_operation(REM, a, b, 0, 0);
        end else begin
            run_operation(DIVU, a, b, busy_pulses, stall_cycles);
            run_operation(REMU, a, b, 0, 0);
        end
    endtask

    // Ends a run that hangs
    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        seed         = 32'h61c4;
        value_errors = 0;
        cycle_count  = 0;
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        clk_en_i     = 1'b1;
        data_valid_i = 1'b0;
        dividend_i   = '0;
        divisor_i    = '0;
        operation_i  = DIVU;
        repeat (5) @(negedge clk_i);
        rst_n_i = 1'b1;

        // ------------------------------
        // Directed operands
        // ------------------------------
        run_pair(1'b0, 32'd100, 32'd7, 0, 0);
        run_pair(1'b0, 32'd7, 32'd100, 1, 0);
        run_pair(1'b0, '1, '1, 0, 0);
        run_pair(1'b0, '1, 32'd1, 0, 0);
        run_pair(1'b0, 32'hdead_beef, 32'h0001_0000, 0, 3);
        run_pair(1'b0, 32'h1234_5678, '1, 0, 0);
        run_pair(1'b0, 32'd0, 32'd5, 0, 0);
        run_pair(1'b1, 32'd20, 32'd3, 0, 0);
        run_pair(1'b1, -32'sd20, 32'd3, 2, 0);
        run_pair(1'b1, 32'd20, -32'sd3, 0, 5);
        run_pair(1'b1, -32'sd20, -32'sd3, 0, 0);
        run_pair(1'b1, 32'd3, -32'sd20, 0, 0);
        run_pair(1'b1, MOST_NEGATIVE, -32'sd1, 1, 0);
        run_pair(1'b1, MOST_NEGATIVE, 32'd1, 0, 0);
        run_pair(1'b1, MOST_NEGATIVE, MOST_NEGATIVE, 0, 0);
        run_pair(1'b1, 32'h7fff_ffff, -32'sd2, 0, 2);
        // Zero divisor on every operation, negative dividends included
        for (int op = 0; op < 4; op++) begin
            run_operation(div_operation_t'(op[1:0]), 32'd1234, '0, 0, 0);
            run_operation(div_operation_t'(op[1:0]), MOST_NEGATIVE, '0, 0, 0);
            run_operation(div_operation_t'(op[1:0]), -32'sd10, '0, 1, 0);
            run_operation(div_operation_t'(op[1:0]), '0, '0, 0, 0);
        end

        // ------------------------------
        // Random operands
        // ------------------------------
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rand_op       = 2'($random(seed));
            rand_dividend = $random(seed);
            // Shorter divisors give longer quotients
            rand_divisor  = $random(seed) >> (i % W);
            run_operation(div_operation_t'(rand_op), rand_dividend, rand_divisor,
                          i % 3, (i % 10 == 0) ? 4 : 0);
        end

        repeat (3) @(negedge clk_i);
        $display("value errors: %0d, assertion failures: %0d", value_errors,
                 division_unit_inst.assertions_inst.failure_count);
        if (value_errors == 0 && division_unit_inst.assertions_inst.failure_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : division_unit_tb

// ==== sim.f ====
+incdir+src
src/div_pkg.sv
src/div_operand_conditioner.sv
src/non_restoring_divider.sv
src/div_result_corrector.sv
src/division_unit.sv
verif/division_unit_assertions.sv
verif/division_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the division unit testbench with Verilator and runs it
# Exits with a failing status unless the run reports a pass
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module division_unit_tb -f sim.f

output=$(./obj_dir/Vdivision_unit_tb +verilator+error+limit+10000 2>&1) || true
echo "$output"

if echo "$output" | grep -q "RESULT: PASS"; then
    exit 0
fi
exit 1
